// File: Bender.yml
package:
  name: rvsystem

sources:
  - common/rvPkg.sv
  - rvCore/rvRegFile.sv
  - rvCore/rvAlu.sv
  - rvCore/rvCore.sv
  - verilog/wbRam.sv
  - verilog/rvSystem.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/rvSystem_asserts.sv
      - dv/rvSystemTb.sv

// File: common/rvPkg.sv
package rvPkg;

    // datapath and address width
    localparam int xlen = 32;

    // each RAM holds memWords 32-bit words
    localparam int memWords    = 1024;
    localparam int memAddrBits = $clog2(memWords); // word index width, 10

    // width of the cycle and retired-instruction counters
    localparam int cntBits = 16;

    // all-ones word ends a program
    localparam logic [xlen-1:0] eofWord = 32'hFFFF_FFFF;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opR      = 7'b011_0011, // add, sub, mul
        opLoad   = 7'b000_0011, // lw
        opImm    = 7'b001_0011, // addi
        opStore  = 7'b010_0011, // sw
        opBranch = 7'b110_0011, // beq, blt
        opLui    = 7'b011_0111,
        opAuipc  = 7'b001_0111
    } opcodeT;

    // multicycle control states
    typedef enum logic [2:0] {
        stIdle,   // waiting for run
        stFetch,  // instruction bus cycle
        stDecode, // operand read, branch target
        stExec,   // alu, branch resolve
        stMem,    // data bus cycle or rd write
        stWb,     // rd write for lw and auipc
        stDone    // end of program seen, parked until rst
    } coreStateT;

endpackage

// File: dv/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    // power-on reset for two edges, released 1 ns after the edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: dv/rvSystemTb.sv
`timescale 1ns/10ps

module rvSystemTb import rvPkg::*; ();

    localparam int nRows = 5; // arith, load/store, branch, auipc, empty

    logic                   clk, rst, porRst, rowRst;
    logic                   run, hostWe, hostSel;
    logic [memAddrBits-1:0] hostAddr;
    logic [xlen-1:0]        hostWdata, hostRdata;
    logic                   done;
    logic [cntBits-1:0]     cycleCount, instrCount;

    logic [31:0] prog [nRows][64]; // program words, eofWord last
    int          progLen [nRows];
    logic [31:0] expD [nRows][16]; // expected data words 0..15
    int          expInstr [nRows];
    int          expCycles [nRows];
    int          seed, checks, errors;

    clockGen clkGen (.clk(clk), .rst(porRst));

    assign rst = porRst | rowRst;

    rvSystem dut (.*);

    bind rvCore rvSystemAsserts asserts (.*);

    // RV32 encoders
    function automatic logic [31:0] encR(input logic [6:0] f7, input int rd, rs1, rs2);
        return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], opR};
    endfunction
    function automatic logic [31:0] encI(input logic [6:0] opc, input logic [2:0] f3,
                                         input int rd, rs1, imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction
    function automatic logic [31:0] encS(input int rs2, rs1, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opStore};
    endfunction
    function automatic logic [31:0] encB(input logic [2:0] f3, input int rs1, rs2, off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opBranch};
    endfunction
    function automatic logic [31:0] encU(input logic [6:0] opc, input int rd, imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    // data RAM word before a run, distinct per address
    function automatic logic [31:0] fillWord(input int addr);
        return 32'hA5A5_0000 ^ addr;
    endfunction

    // cycles from fetch to next fetch
    function automatic int costOf(input logic [6:0] opc);
        case (opc)
            opLoad:   return 7;
            opAuipc:  return 6;
            opBranch: return 4;
            default:  return 5; // alu ops, lui, sw
        endcase
    endfunction

    task automatic emit(input int row, input logic [31:0] word);
        prog[row][progLen[row]] = word;
        progLen[row]++;
    endtask

    task automatic buildTable();
        emit(0, encU(opLui, 1, $random(seed))); // random operands
        emit(0, encI(opImm, 3'b000, 1, 1, $random(seed)));
        emit(0, encU(opLui, 2, $random(seed)));
        emit(0, encI(opImm, 3'b000, 2, 2, $random(seed)));
        emit(0, encR(7'h00, 3, 1, 2)); // add
        emit(0, encR(7'h20, 4, 1, 2)); // sub
        emit(0, encR(7'h01, 5, 1, 2)); // mul
        emit(0, encS(3, 0, 0));
        emit(0, encS(4, 0, 4));
        emit(0, encS(5, 0, 8));
        emit(1, encI(opImm, 3'b000, 1, 0, $random(seed)));
        emit(1, encS(1, 0, 12));
        emit(1, encI(opLoad, 3'b010, 2, 0, 12)); // reload into x2
        emit(1, encI(opImm, 3'b000, 2, 2, $random(seed)));
        emit(1, encS(2, 0, 16));
        emit(1, encI(opImm, 3'b000, 0, 0, $random(seed))); // x0 stays zero
        emit(1, encI(opLoad, 3'b010, 0, 0, 12));
        emit(1, encS(0, 0, 20));
        emit(2, encI(opImm, 3'b000, 1, 0, 5)); // loop counter
        emit(2, encI(opImm, 3'b000, 2, 0, 0));
        emit(2, encI(opImm, 3'b000, 2, 2, $random(seed))); // loop body at byte 8
        emit(2, encI(opImm, 3'b000, 1, 1, -1));
        emit(2, encB(3'b100, 0, 1, -8)); // blt x0, x1 back to 8
        emit(2, encB(3'b000, 0, 0, 8));  // beq skips next word
        emit(2, encI(opImm, 3'b000, 2, 2, 1));
        emit(2, encS(2, 0, 0));
        emit(2, encS(1, 0, 4));
        emit(3, encI(opImm, 3'b000, 1, 0, 1));
        emit(3, encU(opAuipc, 3, $random(seed))); // at byte 4
        emit(3, encS(3, 0, 0));
        emit(3, encU(opAuipc, 4, $random(seed))); // at byte 12
        emit(3, encS(4, 0, 4));
        for (int r = 0; r < nRows; r++)
            emit(r, eofWord); // row 4 is only this
    endtask

    // instruction-level model, gives data words and both counts
    task automatic refRun(input int row);
        logic [31:0] x [32];
        logic [31:0] dm [16];
        logic [31:0] pc, ir, a, b, v, ea, iIm, sIm, bIm, uIm;
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        for (int i = 0; i < 16; i++)
            dm[i] = fillWord(i);
        pc = '0;
        expInstr[row]  = 0;
        expCycles[row] = 3; // fetch and decode of eofWord
        while (prog[row][pc[7:2]] != eofWord && expInstr[row] < 1000) begin
            ir  = prog[row][pc[7:2]];
            a   = x[ir[19:15]];
            b   = x[ir[24:20]];
            iIm = {{20{ir[31]}}, ir[31:20]};
            sIm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            bIm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            uIm = {ir[31:12], 12'b0};
            ea  = a + ((ir[6:0] == opStore) ? sIm : iIm);
            case (ir[6:0])
                opR:     v = ir[25] ? a * b : (ir[30] ? a - b : a + b);
                opImm:   v = a + iIm;
                opLui:   v = uIm;
                opAuipc: v = pc + uIm; // own address
                opLoad:  v = dm[ea[5:2]];
                default: v = x[ir[11:7]]; // sw, branches leave rd
            endcase
            if (ir[6:0] == opStore)
                dm[ea[5:2]] = b;
            x[ir[11:7]] = v;
            x[0] = '0;
            expInstr[row]++;
            expCycles[row] += costOf(ir[6:0]);
            if (ir[6:0] == opBranch && (ir[14] ? $signed(a) < $signed(b) : a == b))
                pc = pc + bIm;
            else
                pc = pc + 4;
        end
        for (int i = 0; i < 16; i++)
            expD[row][i] = dm[i];
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // entered and left 1 ns after an edge
    task automatic hostWrite(input logic sel, input int addr, input logic [31:0] data);
        hostSel   = sel;
        hostAddr  = addr[memAddrBits-1:0];
        hostWdata = data;
        hostWe    = 1'b1;
        @(posedge clk); // word written here
        #1;
    endtask

    task automatic runRow(input int r);
        rowRst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rowRst = 1'b0;
        checkEq("done after rst", done, 0);
        checkEq("cycleCount after rst", cycleCount, 0);
        checkEq("instrCount after rst", instrCount, 0);
        for (int i = 0; i < progLen[r]; i++)
            hostWrite(1'b0, i, prog[r][i]);
        for (int i = 0; i < 16; i++)
            hostWrite(1'b1, i, fillWord(i)); // untouched words keep their fill
        hostWe = 1'b0;
        run    = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!done);
        run = 1'b0;
        checkEq($sformatf("row %0d instrCount", r), instrCount, expInstr[r]);
        checkEq($sformatf("row %0d cycleCount", r), cycleCount, expCycles[r]);
        hostSel = 1'b1;
        for (int i = 0; i < 16; i++) begin
            hostAddr = i[memAddrBits-1:0];
            @(negedge clk); // comb readback settled
            checkEq($sformatf("row %0d dMem[%0d]", r, i), hostRdata, expD[r][i]);
            @(posedge clk);
            #1;
        end
        checkEq("done held", done, 1);
    endtask

    initial begin
        int limit;
        seed      = 53040;
        checks    = 0;
        errors    = 0;
        run       = 1'b0;
        rowRst    = 1'b0;
        hostWe    = 1'b0;
        hostSel   = 1'b0;
        hostAddr  = '0;
        hostWdata = '0;
        buildTable();
        limit = 0;
        for (int r = 0; r < nRows; r++) begin
            refRun(r);
            limit += expCycles[r] + 200; // reset, load, readback per row
        end
        fork
            begin
                #(limit * 10);
                $display("TIMEOUT: core never raised done, watchdog stopped at %0t ns", $time);
                $display("Some tests failed");
                $finish;
            end
        join_none
        wait (!porRst);
        @(posedge clk);
        #1;
        for (int r = 0; r < nRows; r++)
            runRow(r);
        $display("checks %0d errors %0d assertion failures %0d", checks, errors,
                 dut.core.asserts.failCount);
        if (errors == 0 && dut.core.asserts.failCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: dv/rvSystem_asserts.sv
`timescale 1ns/10ps

module rvSystemAsserts import rvPkg::*; (
    input logic            clk,
    input logic            rst,
    input logic            iCyc,
    input logic            iStb,
    input logic            iAck,
    input logic [xlen-1:0] iAdr,
    input logic            dCyc,
    input logic            dStb,
    input logic            dAck,
    input logic [xlen-1:0] dAdr,
    input logic            done
);

    int failCount = 0; // failed assertions so far

    // stb only inside a bus cycle
    iStbCyc: assert property (@(posedge clk) disable iff (rst) iStb |-> iCyc)
        else begin
            $error("instruction bus stb without cyc");
            failCount++;
        end
    dStbCyc: assert property (@(posedge clk) disable iff (rst) dStb |-> dCyc)
        else begin
            $error("data bus stb without cyc");
            failCount++;
        end

    // request and address held until the slave acks
    iHold: assert property (@(posedge clk) disable iff (rst)
        iStb && !iAck |=> iStb && $stable(iAdr))
        else begin
            $error("instruction request dropped or moved before ack");
            failCount++;
        end
    dHold: assert property (@(posedge clk) disable iff (rst)
        dStb && !dAck |=> dStb && $stable(dAdr))
        else begin
            $error("data request dropped or moved before ack");
            failCount++;
        end

    // slave acks only an open request
    iAckStb: assert property (@(posedge clk) disable iff (rst) iAck |-> iStb)
        else begin
            $error("instruction ack without stb");
            failCount++;
        end
    dAckStb: assert property (@(posedge clk) disable iff (rst) dAck |-> dStb)
        else begin
            $error("data ack without stb");
            failCount++;
        end

    // done is sticky, only rst clears it
    doneHeld: assert property (@(posedge clk) disable iff (rst) done |=> done)
        else begin
            $error("done fell without rst");
            failCount++;
        end

endmodule

// File: rvCore/rvAlu.sv
`timescale 1ns/10ps

module rvAlu import rvPkg::*; (
    input  opcodeT          opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [xlen-1:0] opA,
    input  logic [xlen-1:0] opB,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] pcCur,
    output logic [xlen-1:0] result,
    output logic            taken
);

    always_comb begin
        result = '0;
        case (opcode)
            opR: begin
                if (funct3 == 3'b000) begin
                    case (funct7)
                        7'b000_0000: result = opA + opB;
                        7'b010_0000: result = opA - opB;
                        7'b000_0001: result = opA * opB; // low 32 bits only
                        default:     result = '0;
                    endcase
                end
            end
            opImm, opLoad, opStore: result = opA + imm; // addi or effective address
            opLui:                  result = imm;
            opAuipc:                result = pcCur + imm;
            default:                result = '0;
        endcase
    end

    // branch condition on the latched operands
    always_comb begin
        taken = 1'b0;
        if (opcode == opBranch) begin
            case (funct3)
                3'b000:  taken = (opA == opB);                   // beq
                3'b100:  taken = ($signed(opA) < $signed(opB)); // blt
                default: taken = 1'b0;
            endcase
        end
    end

endmodule

// File: rvCore/rvCore.sv
`timescale 1ns/10ps

module rvCore import rvPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    output logic               iCyc,
    output logic               iStb,
    output logic [xlen-1:0]    iAdr,
    input  logic [xlen-1:0]    iDatR,
    input  logic               iAck,
    output logic               dCyc,
    output logic               dStb,
    output logic               dWe,
    output logic [xlen-1:0]    dAdr,
    output logic [xlen-1:0]    dDatW,
    input  logic [xlen-1:0]    dDatR,
    input  logic               dAck,
    output logic               done,
    output logic [cntBits-1:0] cycleCount,
    output logic [cntBits-1:0] instrCount
);

    coreStateT       state;
    logic [xlen-1:0] pc, pcCur, ir;    // pcCur is the address of the instruction in ir
    logic [xlen-1:0] rs1Q, rs2Q;       // latched operands
    logic [xlen-1:0] aluOut, mdr;
    opcodeT          op;
    logic [xlen-1:0] iImm, sImm, bImm, uImm, immSel;
    logic [xlen-1:0] rs1Data, rs2Data, rdData;
    logic [xlen-1:0] aluResult;
    logic            taken, rdWe, dReq;

    assign op = opcodeT'(ir[6:0]);

    // immediate formats
    assign iImm = {{20{ir[31]}}, ir[31:20]};
    assign sImm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign bImm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign uImm = {ir[31:12], 12'b0};

    always_comb begin
        case (op)
            opStore:        immSel = sImm;
            opLui, opAuipc: immSel = uImm;
            default:        immSel = iImm; // addi, lw
        endcase
    end

    // rd written in mem for alu ops, in wb for lw and auipc
    assign rdWe   = (state == stWb) ||
                    ((state == stMem) && (op == opR || op == opImm || op == opLui));
    assign rdData = (op == opLoad) ? mdr : aluOut;

    rvRegFile regFile (
        .clk     (clk),
        .rst     (rst),
        .rs1Addr (ir[19:15]),
        .rs2Addr (ir[24:20]),
        .rdAddr  (ir[11:7]),
        .rdWe    (rdWe),
        .rdData  (rdData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    rvAlu alu (
        .opcode (op),
        .funct3 (ir[14:12]),
        .funct7 (ir[31:25]),
        .opA    (rs1Q),
        .opB    (rs2Q),
        .imm    (immSel),
        .pcCur  (pcCur),
        .result (aluResult),
        .taken  (taken)
    );

    // instruction master, read only
    assign iCyc = (state == stFetch);
    assign iStb = (state == stFetch);
    assign iAdr = pc;

    // sw starts its bus cycle in exec so it finishes in the first mem cycle
    assign dReq  = ((state == stExec) && (op == opStore)) ||
                   ((state == stMem) && (op == opStore || op == opLoad));
    assign dCyc  = dReq;
    assign dStb  = dReq;
    assign dWe   = (op == opStore);
    assign dAdr  = (state == stExec) ? aluResult : aluOut; // same value across exec->mem
    assign dDatW = rs2Q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= stIdle;
            pc         <= '0;
            done       <= 1'b0;
            cycleCount <= '0;
            instrCount <= '0;
        end else begin
            if (state != stIdle && state != stDone)
                cycleCount <= cycleCount + 1'b1;
            case (state)
                stIdle: begin
                    if (run) begin
                        pc    <= '0;
                        state <= stFetch;
                    end
                end
                stFetch: begin
                    if (iAck) begin // word arrives with ack
                        ir    <= iDatR;
                        pcCur <= pc;
                        pc    <= pc + 4;
                        state <= stDecode;
                    end
                end
                stDecode: begin
                    rs1Q   <= rs1Data;
                    rs2Q   <= rs2Data;
                    aluOut <= pcCur + bImm; // branch target
                    if (ir == eofWord) begin
                        done  <= 1'b1;
                        state <= stDone;
                    end else begin
                        state <= stExec;
                    end
                end
                stExec: begin
                    instrCount <= instrCount + 1'b1;
                    if (op == opBranch) begin
                        if (taken)
                            pc <= aluOut;
                        state <= stFetch;
                    end else if (op == opR || op == opImm || op == opLoad ||
                                 op == opStore || op == opLui || op == opAuipc) begin
                        aluOut <= aluResult;
                        state  <= stMem;
                    end else begin
                        state <= stFetch; // unsupported, skipped
                    end
                end
                stMem: begin
                    if (op == opLoad) begin
                        if (dAck) begin
                            mdr   <= dDatR;
                            state <= stWb;
                        end
                    end else if (op == opStore) begin
                        if (dAck)
                            state <= stFetch;
                    end else if (op == opAuipc) begin
                        state <= stWb;
                    end else begin
                        state <= stFetch; // rd written this cycle
                    end
                end
                stWb: state <= stFetch;
                stDone: state <= stDone; // held until rst
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// File: rvCore/rvRegFile.sv
`timescale 1ns/10ps

module rvRegFile import rvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1Addr,
    input  logic [4:0]      rs2Addr,
    input  logic [4:0]      rdAddr,
    input  logic            rdWe,
    input  logic [xlen-1:0] rdData,
    output logic [xlen-1:0] rs1Data,
    output logic [xlen-1:0] rs2Data
);

    logic [xlen-1:0] regs [32];

    // x0 never written so it reads zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (rdWe && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = regs[rs1Addr]; // async read
    assign rs2Data = regs[rs2Addr];

endmodule

// File: rvSystem.f
common/rvPkg.sv
rvCore/rvRegFile.sv
rvCore/rvAlu.sv
rvCore/rvCore.sv
verilog/wbRam.sv
verilog/rvSystem.sv
dv/clockGen.sv
dv/rvSystem_asserts.sv
dv/rvSystemTb.sv

// File: verilog/rvSystem.sv
`timescale 1ns/10ps

module rvSystem import rvPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   hostWe,
    input  logic                   hostSel,   // 0 imem, 1 dmem
    input  logic [memAddrBits-1:0] hostAddr,
    input  logic [xlen-1:0]        hostWdata,
    output logic [xlen-1:0]        hostRdata,
    output logic                   done,
    output logic [cntBits-1:0]     cycleCount,
    output logic [cntBits-1:0]     instrCount
);

    logic            iCyc, iStb, iAck;
    logic [xlen-1:0] iAdr, iDatR;
    logic            dCyc, dStb, dWe, dAck;
    logic [xlen-1:0] dAdr, dDatW, dDatR;
    logic [xlen-1:0] iHostRdata, dHostRdata;

    rvCore core (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .iCyc       (iCyc),
        .iStb       (iStb),
        .iAdr       (iAdr),
        .iDatR      (iDatR),
        .iAck       (iAck),
        .dCyc       (dCyc),
        .dStb       (dStb),
        .dWe        (dWe),
        .dAdr       (dAdr),
        .dDatW      (dDatW),
        .dDatR      (dDatR),
        .dAck       (dAck),
        .done       (done),
        .cycleCount (cycleCount),
        .instrCount (instrCount)
    );

    // instruction RAM, core side never writes
    wbRam iMem (
        .clk       (clk),
        .cyc       (iCyc),
        .stb       (iStb),
        .we        (1'b0),
        .adr       (iAdr),
        .datW      ('0),
        .datR      (iDatR),
        .ack       (iAck),
        .hostWe    (hostWe && !hostSel),
        .hostAddr  (hostAddr),
        .hostWdata (hostWdata),
        .hostRdata (iHostRdata)
    );

    wbRam dMem (
        .clk       (clk),
        .cyc       (dCyc),
        .stb       (dStb),
        .we        (dWe),
        .adr       (dAdr),
        .datW      (dDatW),
        .datR      (dDatR),
        .ack       (dAck),
        .hostWe    (hostWe && hostSel),
        .hostAddr  (hostAddr),
        .hostWdata (hostWdata),
        .hostRdata (dHostRdata)
    );

    assign hostRdata = hostSel ? dHostRdata : iHostRdata;

endmodule

// File: verilog/wbRam.sv
`timescale 1ns/10ps

module wbRam import rvPkg::*; (
    input  logic                   clk,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [xlen-1:0]        adr,
    input  logic [xlen-1:0]        datW,
    output logic [xlen-1:0]        datR,
    output logic                   ack,
    input  logic                   hostWe,
    input  logic [memAddrBits-1:0] hostAddr,
    input  logic [xlen-1:0]        hostWdata,
    output logic [xlen-1:0]        hostRdata
);

    logic [xlen-1:0]        mem [memWords];
    logic [memAddrBits-1:0] wordIdx;
    logic                   req;

    assign wordIdx = adr[memAddrBits+1:2]; // byte address to word index

    // new request only while no ack is out, so one ack per request
    assign req = cyc && stb && !ack;

    // ack one cycle after the request
    always_ff @(posedge clk) begin
        ack <= req;
    end

    always_ff @(posedge clk) begin
        if (hostWe)
            mem[hostAddr] <= hostWdata; // host load, core idle
        else if (req && we)
            mem[wordIdx] <= datW;
        if (req)
            datR <= mem[wordIdx]; // registered read, valid with ack
    end

    // host readback
    assign hostRdata = mem[hostAddr];

endmodule
